// ==== Makefile ====
TOP := tb_am_lock

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f build.f --top-module am_lock_top

clean:
	rm -rf obj_dir sim.log

// ==== am_cfg_if.sv ====
`timescale 1ns/1ps

interface am_cfg_if;
        import am_pkg::*;
        import am_cfg_pkg::*;

        logic           enable;
        valid_thr_t     valid_thr;
        invalid_thr_t   invalid_thr;
        am_bytes_t      compare_mask;
        am_period_t     am_period;

        modport regs
        (
                output enable, valid_thr, invalid_thr, compare_mask, am_period
        );

        // shared by every lane.
        modport lane
        (
                input  enable, valid_thr, invalid_thr, compare_mask, am_period
        );

endinterface

// ==== am_cfg_pkg.sv ====
package am_cfg_pkg;

        typedef logic [2:0]     cfg_addr_t;
        typedef logic [31:0]    cfg_data_t;
        typedef logic [4:0]     valid_thr_t;    // good markers to lock.
        typedef logic [2:0]     invalid_thr_t;  // bad markers to unlock.
        typedef logic [15:0]    am_period_t;    // marker spacing in valid blocks.

        localparam cfg_addr_t ADDR_CTRL        = 3'd0;  // bit 0 enable.
        localparam cfg_addr_t ADDR_VALID_THR   = 3'd1;
        localparam cfg_addr_t ADDR_INVALID_THR = 3'd2;
        localparam cfg_addr_t ADDR_MASK_LO     = 3'd3;  // mask 31:0.
        localparam cfg_addr_t ADDR_MASK_HI     = 3'd4;  // mask 47:32.
        localparam cfg_addr_t ADDR_PERIOD      = 3'd5;

        localparam valid_thr_t          RST_VALID_THR   = 5'd5;
        localparam invalid_thr_t        RST_INVALID_THR = 3'd3;
        localparam am_pkg::am_bytes_t   RST_MASK        = '1;
        localparam am_period_t          RST_PERIOD      = 16'd16383;

endpackage

// ==== am_cfg_regs.sv ====
`timescale 1ns/1ps

module am_cfg_regs
(
        input  logic                    i_clock,
        input  logic                    i_arst_n,
        input  logic                    i_cfg_wr,
        input  am_cfg_pkg::cfg_addr_t   i_cfg_addr,
        input  am_cfg_pkg::cfg_data_t   i_cfg_wdata,
        am_cfg_if.regs                  cfg
);
        import am_pkg::*;
        import am_cfg_pkg::*;

        logic           enable;
        valid_thr_t     valid_thr;
        invalid_thr_t   invalid_thr;
        am_bytes_t      compare_mask;
        am_period_t     am_period;

        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        enable       <= 1'b0;
                        valid_thr    <= RST_VALID_THR;
                        invalid_thr  <= RST_INVALID_THR;
                        compare_mask <= RST_MASK;
                        am_period    <= RST_PERIOD;
                end
                else if (i_cfg_wr)
                begin
                        // unknown addresses fall through.
                        case (i_cfg_addr)
                        ADDR_CTRL:
                                enable <= i_cfg_wdata[0];
                        ADDR_VALID_THR:
                                valid_thr <= i_cfg_wdata[$bits(valid_thr_t)-1:0];
                        ADDR_INVALID_THR:
                                invalid_thr <= i_cfg_wdata[$bits(invalid_thr_t)-1:0];
                        ADDR_MASK_LO:
                                compare_mask[31:0] <= i_cfg_wdata;
                        ADDR_MASK_HI:
                                compare_mask[NB_AM-1:32] <= i_cfg_wdata[NB_AM-33:0];
                        ADDR_PERIOD:
                                am_period <= i_cfg_wdata[$bits(am_period_t)-1:0];
                        default:
                        begin
                        end
                        endcase
                end
        end

        assign cfg.enable       = enable;
        assign cfg.valid_thr    = valid_thr;
        assign cfg.invalid_thr  = invalid_thr;
        assign cfg.compare_mask = compare_mask;
        assign cfg.am_period    = am_period;

endmodule

// ==== am_lane_lock.sv ====
`timescale 1ns/1ps

module am_lane_lock
(
        input  logic                    i_clock,
        input  logic                    i_arst_n,
        input  logic                    i_valid,
        input  logic                    i_block_lock,
        input  am_pkg::am_block_t       i_data,
        am_cfg_if.lane                  cfg,
        output am_pkg::am_block_t       o_data,
        output logic                    o_valid,
        output am_pkg::lane_id_t        o_lane_id,
        output am_pkg::err_count_t      o_error_counter,
        output logic                    o_am_lock,
        output logic                    o_resync,
        output am_pkg::resync_count_t   o_resync_counter,
        output logic                    o_start_of_lane
);
        import am_pkg::*;
        import am_cfg_pkg::*;

        typedef enum logic [1:0] {ST_SEARCH, ST_VERIFY, ST_LOCKED} state_t;

        state_t         state;
        logic           hit;
        lane_id_t       hit_id;
        lane_id_t       lane_id;
        am_period_t     pos_cnt;
        am_period_t     pos_reload;
        valid_thr_t     good_cnt;
        valid_thr_t     good_inc;
        invalid_thr_t   bad_cnt;
        invalid_thr_t   bad_inc;
        err_count_t     err_cnt;
        resync_count_t  resync_cnt;
        am_block_t      data_q;
        logic           valid_q;
        logic           sol;
        logic           resync;
        logic           lane_up;
        logic           at_am;
        logic           same_am;

        am_matcher am_matcher_i
        (
                .i_block        (i_data),
                .i_mask         (cfg.compare_mask),
                .o_hit          (hit),
                .o_hit_id       (hit_id)
        );

        assign lane_up    = i_block_lock && cfg.enable;
        assign at_am      = (pos_cnt == '0);                    // expected marker slot.
        assign same_am    = hit && (hit_id == lane_id);
        assign pos_reload = cfg.am_period - am_period_t'(1);
        assign good_inc   = good_cnt + valid_thr_t'(1);
        assign bad_inc    = bad_cnt + invalid_thr_t'(1);

        // payload stage.
        always_ff @(posedge i_clock)
        begin
                data_q <= i_data;
        end

        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        state      <= ST_SEARCH;
                        valid_q    <= 1'b0;
                        lane_id    <= '0;
                        pos_cnt    <= '0;
                        good_cnt   <= '0;
                        bad_cnt    <= '0;
                        err_cnt    <= '0;
                        resync_cnt <= '0;
                        sol        <= 1'b0;
                        resync     <= 1'b0;
                end
                else
                begin
                        valid_q <= i_valid;
                        sol     <= 1'b0;
                        resync  <= 1'b0;
                        if (!lane_up)
                        begin
                                state    <= ST_SEARCH;                  // no counting here.
                                good_cnt <= '0;
                                bad_cnt  <= '0;
                        end
                        else if (i_valid)
                        begin
                                pos_cnt <= pos_cnt - am_period_t'(1);
                                case (state)
                                ST_SEARCH:
                                begin
                                        if (hit)
                                        begin
                                                lane_id  <= hit_id;
                                                good_cnt <= valid_thr_t'(1);
                                                bad_cnt  <= '0;
                                                pos_cnt  <= pos_reload;
                                                if (cfg.valid_thr <= valid_thr_t'(1))
                                                        state <= ST_LOCKED;
                                                else
                                                        state <= ST_VERIFY;
                                        end
                                end
                                ST_VERIFY:
                                begin
                                        if (at_am)
                                        begin
                                                pos_cnt <= pos_reload;
                                                if (!same_am)
                                                        state <= ST_SEARCH;
                                                else
                                                begin
                                                        good_cnt <= good_inc;
                                                        if (good_inc >= cfg.valid_thr)
                                                                state <= ST_LOCKED;
                                                end
                                        end
                                end
                                ST_LOCKED:
                                begin
                                        if (at_am)
                                        begin
                                                pos_cnt <= pos_reload;
                                                if (same_am)
                                                begin
                                                        bad_cnt <= '0;
                                                        sol     <= 1'b1;
                                                end
                                                else
                                                begin
                                                        bad_cnt <= bad_inc;
                                                        if (err_cnt != '1)
                                                                err_cnt <= err_cnt + err_count_t'(1);
                                                        if (bad_inc >= cfg.invalid_thr)
                                                        begin
                                                                // too many bad markers drop lock.
                                                                state  <= ST_SEARCH;
                                                                resync <= 1'b1;
                                                                if (resync_cnt != '1)
                                                                        resync_cnt <= resync_cnt + resync_count_t'(1);
                                                        end
                                                end
                                        end
                                end
                                default:
                                        state <= ST_SEARCH;
                                endcase
                        end
                end
        end

        assign o_data           = data_q;
        assign o_valid          = valid_q;
        assign o_lane_id        = lane_id;
        assign o_error_counter  = err_cnt;
        assign o_am_lock        = (state == ST_LOCKED);
        assign o_resync         = resync;
        assign o_resync_counter = resync_cnt;
        assign o_start_of_lane  = sol;

endmodule

// ==== am_lock_top.sv ====
`timescale 1ns/1ps

module am_lock_top
(
        input  logic                            i_clock,
        input  logic                            i_arst_n,

        input  logic                            i_cfg_wr,
        input  am_cfg_pkg::cfg_addr_t           i_cfg_addr,
        input  am_cfg_pkg::cfg_data_t           i_cfg_wdata,

        input  logic                            i_valid,
        input  logic [am_pkg::N_LANES-1:0]      i_block_lock,
        input  am_pkg::am_block_t               i_data [am_pkg::N_LANES],

        output am_pkg::am_block_t               o_data [am_pkg::N_LANES],
        output logic                            o_valid,
        output am_pkg::lane_id_t                o_lane_id [am_pkg::N_LANES],
        output am_pkg::err_count_t              o_error_counter [am_pkg::N_LANES],
        output logic [am_pkg::N_LANES-1:0]      o_am_lock,
        output logic [am_pkg::N_LANES-1:0]      o_resync,
        output am_pkg::resync_count_t           o_resync_counter [am_pkg::N_LANES],
        output logic [am_pkg::N_LANES-1:0]      o_start_of_lane
);
        import am_pkg::*;

        logic [N_LANES-1:0]     lane_valid;

        am_cfg_if am_cfg_if_i ();

        am_cfg_regs am_cfg_regs_i
        (
                .i_clock        (i_clock),
                .i_arst_n       (i_arst_n),
                .i_cfg_wr       (i_cfg_wr),
                .i_cfg_addr     (i_cfg_addr),
                .i_cfg_wdata    (i_cfg_wdata),
                .cfg            (am_cfg_if_i.regs)
        );

        for (genvar i = 0; i < N_LANES; i++)
        begin : g_lane
                am_lane_lock am_lane_lock_i
                (
                        .i_clock                (i_clock),
                        .i_arst_n               (i_arst_n),
                        .i_valid                (i_valid),
                        .i_block_lock           (i_block_lock[i]),
                        .i_data                 (i_data[i]),
                        .cfg                    (am_cfg_if_i.lane),
                        .o_data                 (o_data[i]),
                        .o_valid                (lane_valid[i]),
                        .o_lane_id              (o_lane_id[i]),
                        .o_error_counter        (o_error_counter[i]),
                        .o_am_lock              (o_am_lock[i]),
                        .o_resync               (o_resync[i]),
                        .o_resync_counter       (o_resync_counter[i]),
                        .o_start_of_lane        (o_start_of_lane[i])
                );
        end

        assign o_valid = lane_valid[0];                 // all lanes share one valid.

endmodule

// ==== am_matcher.sv ====
`timescale 1ns/1ps

module am_matcher
(
        input  am_pkg::am_block_t       i_block,
        input  am_pkg::am_bytes_t       i_mask,
        output logic                    o_hit,
        output am_pkg::lane_id_t        o_hit_id
);
        import am_pkg::*;

        am_bytes_t              m_bytes;
        logic                   sync_ok;
        logic [N_ALIGNER-1:0]   match;

        // payload is M0 M1 M2 BIP3 M4 M5 M6 BIP7 from the top down.
        assign m_bytes = {i_block[63:40], i_block[31:8]};
        assign sync_ok = (i_block[NB_BLOCK-1:NB_BLOCK-2] == AM_SYNC);

        always_comb
        begin
                for (int k = 0; k < N_ALIGNER; k++)
                begin
                        // masked-out bits never count.
                        match[k] = sync_ok && (((m_bytes ^ AM_TABLE[k]) & i_mask) == '0);
                end
        end

        // lowest index wins.
        always_comb
        begin
                o_hit    = 1'b0;
                o_hit_id = '0;
                for (int k = N_ALIGNER - 1; k >= 0; k--)
                begin
                        if (match[k])
                        begin
                                o_hit    = 1'b1;
                                o_hit_id = lane_id_t'(k);
                        end
                end
        end

endmodule

// ==== am_pkg.sv ====
package am_pkg;

        localparam int N_LANES   = 4;
        localparam int N_ALIGNER = 4;
        localparam int NB_BLOCK  = 66;
        localparam int NB_AM     = 48;

        // sync header in bits 65:64, payload byte 0 in bits 63:56.
        typedef logic [NB_BLOCK-1:0]            am_block_t;

        // M0 M1 M2 M4 M5 M6, bip bytes dropped.
        typedef logic [NB_AM-1:0]               am_bytes_t;

        typedef logic [$clog2(N_ALIGNER)-1:0]   lane_id_t;
        typedef logic [15:0]                    err_count_t;
        typedef logic [7:0]                     resync_count_t;

        // control block header.
        localparam logic [1:0] AM_SYNC = 2'b10;

        // lane 0 to 3 markers of 802.3 clause 82.
        localparam am_bytes_t AM_TABLE [N_ALIGNER] = '{
                48'hC1_68_21_3E_97_DE,
                48'h9D_71_8E_62_8E_71,
                48'h59_4B_E8_A6_B4_17,
                48'h4D_95_7B_B2_6A_84
        };

endpackage

// ==== am_stimulus.txt ====
# W addr data | B lock code0 code1 code2 code3 sol | R n | I n | E lock ids errs resyncs
# hex, lane 0 lowest; codes D data, Mn marker, Xn masked-in flip, Yn masked-out flip
W 5 00000008
W 1 00000003
W 3 FFFFFF00
W 0 00000001
R 3
B F M3 M2 M1 M0 0
E 0 1B 0000 0000
R 4
I 2
R 3
B F M3 M2 M1 M0 0
R 7
B F M3 M2 M1 M0 0
E F 1B 0000 0000
R 7
B F M3 M2 M1 M0 F
R 7
B F Y3 Y2 Y1 Y0 F
W 3 00FFFF00
R 7
B F Y3 Y2 Y1 Y0 F
E F 1B 0000 0000
R 7
B F X3 M2 M1 M0 E
E F 1B 0001 0000
R 7
B F M3 M2 M1 M0 F
R 7
B F X3 M2 M1 M0 E
R 7
B F X3 M2 M1 M0 E
R 7
B F X3 M2 M1 M0 E
E E 1B 0004 0001
R 7
B F M3 M2 M1 M0 E
R 7
B F M3 M2 M1 M0 E
R 7
B F M3 M2 M1 M0 E
E F 1B 0004 0001
R 7
B F M3 M2 M1 M0 F
B 7 D D D D 0
E 7 1B 0004 0001
R 6
B 7 M3 M2 M1 M0 7
W 0 00000000
I 1
E 0 1B 0004 0001
R 2

// ==== build.f ====
am_pkg.sv
am_cfg_pkg.sv
am_cfg_if.sv
am_cfg_regs.sv
am_matcher.sv
am_lane_lock.sv
am_lock_top.sv
tb_am_lock.sv

// ==== tb_am_lock.sv ====
`timescale 1ns/1ps

module tb_am_lock;
        import am_pkg::*;
        import am_cfg_pkg::*;

        localparam int HALF_PERIOD = 50;
        localparam int DRIVE_DLY   = 10;
        localparam int WAIT_MAX    = 20;

        // clause 82 markers for lanes 0 to 3 as M0 M1 M2 M4 M5 M6.
        localparam am_bytes_t MARKERS [4] = '{
                48'hC1_68_21_3E_97_DE,
                48'h9D_71_8E_62_8E_71,
                48'h59_4B_E8_A6_B4_17,
                48'h4D_95_7B_B2_6A_84
        };

        logic                   i_clock;
        logic                   i_arst_n;
        logic                   i_cfg_wr;
        cfg_addr_t              i_cfg_addr;
        cfg_data_t              i_cfg_wdata;
        logic                   i_valid;
        logic [N_LANES-1:0]     i_block_lock;
        am_block_t              i_data [N_LANES];
        am_block_t              o_data [N_LANES];
        logic                   o_valid;
        lane_id_t               o_lane_id [N_LANES];
        err_count_t             o_error_counter [N_LANES];
        logic [N_LANES-1:0]     o_am_lock;
        logic [N_LANES-1:0]     o_resync;
        resync_count_t          o_resync_counter [N_LANES];
        logic [N_LANES-1:0]     o_start_of_lane;

        logic [31:0]            rng_state;
        int                     errors;
        int                     checks;
        logic                   timed_out;
        am_block_t              exp_q [$];      // blocks still in flight with lane 0 first.
        logic                   exp_valid;
        logic [N_LANES-1:0]     exp_sol;
        logic                   status_due;
        logic [N_LANES-1:0]     exp_lock;
        logic [7:0]             exp_ids;        // 2 bits per lane.
        logic [15:0]            exp_errs;       // one hex digit per lane.
        logic [15:0]            exp_resyncs;
        resync_count_t          pulses [N_LANES];
        logic [N_LANES-1:0]     next_lock;
        am_block_t              next_data [N_LANES];

        am_lock_top am_lock_top_i (.*);

        initial
        begin
                i_clock = 1'b0;
                forever #HALF_PERIOD i_clock = ~i_clock;
        end

        function automatic logic [31:0] next_rand();
                logic [31:0] x;
                x = rng_state;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rng_state = x;
                return x;
        endfunction

        function automatic am_block_t data_block();
                return {2'b01, next_rand(), next_rand()};
        endfunction

        function automatic am_block_t make_block(input logic [15:0] code);
                am_block_t      blk;
                logic [31:0]    bip;
                int             n;
                n = int'(code[7:0]) - 48;
                if (code == {8'h00, "D"})
                        return data_block();
                if (n < 0 || n >= N_LANES || !(code[15:8] inside {"M", "X", "Y"}))
                begin
                        errors++;
                        $display("stimulus file holds an unknown block code");
                        return data_block();
                end
                bip = next_rand();
                blk = {2'b10, MARKERS[n][47:24], bip[7:0], MARKERS[n][23:0], bip[15:8]};
                if (code[15:8] == "X")
                        blk[63] = ~blk[63];     // M0 msb is always compared.
                else if (code[15:8] == "Y")
                        blk[8] = ~blk[8];       // M6 lsb is masked out.
                return blk;
        endfunction

        task automatic check_block(input string name, input am_block_t exp, input am_block_t act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
                end
        endtask

        task automatic check_id(input string name, input lane_id_t exp, input lane_id_t act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
                end
        endtask

        task automatic check_err(input string name, input err_count_t exp, input err_count_t act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
                end
        endtask

        task automatic check_resync(input string name, input resync_count_t exp,
                                    input resync_count_t act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
                end
        endtask

        task automatic check_bits(input string name, input logic [N_LANES-1:0] exp,
                                  input logic [N_LANES-1:0] act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                checks++;
                if (act !== exp)
                begin
                        errors++;
                        $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
                end
        endtask

        // outputs here belong to the inputs taken at the last edge.
        task automatic check_outputs();
                check_flag("o_valid", exp_valid, o_valid);
                check_bits("o_start_of_lane", exp_sol, o_start_of_lane);
                for (int i = 0; i < N_LANES; i++)
                begin
                        if (exp_valid)
                                check_block($sformatf("o_data[%0d]", i), exp_q.pop_front(), o_data[i]);
                        if (o_resync[i])
                                pulses[i]++;
                end
                if (status_due)
                begin
                        status_due = 1'b0;
                        check_bits("o_am_lock", exp_lock, o_am_lock);
                        for (int i = 0; i < N_LANES; i++)
                        begin
                                check_id($sformatf("o_lane_id[%0d]", i),
                                         lane_id_t'(exp_ids[2*i +: 2]), o_lane_id[i]);
                                check_err($sformatf("o_error_counter[%0d]", i),
                                          err_count_t'(exp_errs[4*i +: 4]), o_error_counter[i]);
                                check_resync($sformatf("o_resync_counter[%0d]", i),
                                             resync_count_t'(exp_resyncs[4*i +: 4]),
                                             o_resync_counter[i]);
                                check_resync($sformatf("o_resync pulses[%0d]", i),
                                             resync_count_t'(exp_resyncs[4*i +: 4]), pulses[i]);
                        end
                end
        endtask

        task automatic cycle(input logic valid, input logic [N_LANES-1:0] sol,
                             input logic wr, input cfg_addr_t addr, input cfg_data_t wdata);
                @(posedge i_clock);
                #DRIVE_DLY;
                check_outputs();
                i_valid      = valid;
                i_block_lock = next_lock;
                i_cfg_wr     = wr;
                i_cfg_addr   = addr;
                i_cfg_wdata  = wdata;
                exp_valid    = valid;
                exp_sol      = sol;
                for (int i = 0; i < N_LANES; i++)
                begin
                        i_data[i] = next_data[i];
                        if (valid)
                                exp_q.push_back(next_data[i]);
                end
        endtask

        task automatic wait_reset_done();
                int n;
                n = 0;
                while ((o_valid !== 1'b0 || o_am_lock !== '0) && n < WAIT_MAX)
                begin
                        @(posedge i_clock);
                        n++;
                end
                if (o_valid !== 1'b0 || o_am_lock !== '0)
                begin
                        timed_out = 1'b1;
                        errors++;
                        $display("timeout, the outputs did not settle after reset");
                end
        endtask

        task automatic drain();
                int n;
                n = 0;
                while ((exp_q.size() != 0 || status_due) && n < WAIT_MAX)
                begin
                        cycle(1'b0, '0, 1'b0, '0, '0);
                        n++;
                end
                if (exp_q.size() != 0 || status_due)
                begin
                        timed_out = 1'b1;
                        errors++;
                        $display("timeout, blocks or status checks were left over at the end");
                end
        endtask

        task automatic verify_field_count(input int got, input int want);
                if (got != want)
                begin
                        errors++;
                        $display("stimulus file holds a line with missing or bad fields");
                end
        endtask

        task automatic run_commands(input int fd);
                logic [7:0]             cmd;
                logic [15:0]            code [N_LANES];
                logic [31:0]            a;
                logic [31:0]            b;
                logic [31:0]            c;
                logic [31:0]            d;
                logic [8*128-1:0]       rest;
                int                     rc;
                while ($fscanf(fd, "%s", cmd) == 1)
                begin
                        case (cmd)
                        "#":
                                rc = $fgets(rest, fd);
                        "W":
                        begin
                                rc = $fscanf(fd, "%h %h", a, b);
                                verify_field_count(rc, 2);
                                cycle(1'b0, '0, 1'b1, cfg_addr_t'(a), b);
                        end
                        "B":
                        begin
                                rc = $fscanf(fd, "%h %s %s %s %s %h", a, code[0], code[1],
                                             code[2], code[3], b);
                                verify_field_count(rc, 6);
                                next_lock = a[N_LANES-1:0];
                                for (int i = 0; i < N_LANES; i++)
                                        next_data[i] = make_block(code[i]);
                                cycle(1'b1, b[N_LANES-1:0], 1'b0, '0, '0);
                        end
                        "R":
                        begin
                                rc = $fscanf(fd, "%d", a);
                                verify_field_count(rc, 1);
                                repeat (a)
                                begin
                                        for (int i = 0; i < N_LANES; i++)
                                                next_data[i] = data_block();
                                        cycle(1'b1, '0, 1'b0, '0, '0);
                                end
                        end
                        "I":
                        begin
                                rc = $fscanf(fd, "%d", a);
                                verify_field_count(rc, 1);
                                repeat (a)
                                        cycle(1'b0, '0, 1'b0, '0, '0);
                        end
                        "E":
                        begin
                                rc = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                                verify_field_count(rc, 4);
                                exp_lock    = a[N_LANES-1:0];
                                exp_ids     = b[7:0];
                                exp_errs    = c[15:0];
                                exp_resyncs = d[15:0];
                                status_due  = 1'b1;
                        end
                        default:
                        begin
                                errors++;
                                $display("stimulus file holds an unknown command");
                        end
                        endcase
                end
        endtask

        initial
        begin
                int fd;
                rng_state    = 32'h6adf_3d82;
                errors       = 0;
                checks       = 0;
                timed_out    = 1'b0;
                exp_valid    = 1'b0;
                exp_sol      = '0;
                status_due   = 1'b1;            // reset values are checked first.
                exp_lock     = '0;
                exp_ids      = '0;
                exp_errs     = '0;
                exp_resyncs  = '0;
                i_arst_n     = 1'b0;
                i_cfg_wr     = 1'b0;
                i_cfg_addr   = '0;
                i_cfg_wdata  = '0;
                i_valid      = 1'b0;
                i_block_lock = '0;
                next_lock    = '0;
                for (int i = 0; i < N_LANES; i++)
                begin
                        i_data[i]    = '0;
                        next_data[i] = '0;
                        pulses[i]    = '0;
                end
                repeat (5) @(posedge i_clock);
                #DRIVE_DLY;
                i_arst_n = 1'b1;
                wait_reset_done();
                if (!timed_out)
                begin
                        fd = $fopen("am_stimulus.txt", "r");
                        if (fd == 0)
                        begin
                                errors++;
                                $display("cannot open am_stimulus.txt");
                        end
                        else
                        begin
                                run_commands(fd);
                                $fclose(fd);
                                drain();
                        end
                end
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0 && !timed_out)
                        $display("All tests passed");
                else
                        $display("Some tests failed");
                $finish;
        end

endmodule
